/* Bender.yml */
package:
  name: routerOutputPort

sources:
  - files:
      - verilog/nocArbPkg.sv
      - verilog/holdTimerBank.sv
      - verilog/portArbiter.sv
      - verilog/flitSelector.sv
      - verilog/routerOutputPort.sv

  - target: test
    include_dirs:
      - tb
    files:
      - tb/tbRouterOutputPort.sv

/* build.f */
+incdir+tb
verilog/nocArbPkg.sv
verilog/holdTimerBank.sv
verilog/portArbiter.sv
verilog/flitSelector.sv
verilog/routerOutputPort.sv
tb/tbRouterOutputPort.sv

/* tb/arbModel.svh */
`ifndef ARB_MODEL_SVH
`define ARB_MODEL_SVH

// Next owner of the output port, -1 stands for idle
function automatic int predictGrant(input int cur,
                                    input logic [nocArbPkg::numPorts-1:0] reqMask,
                                    input logic [nocArbPkg::numPorts-1:0] upMask);
  int pick;
  int p;
  pick = -1;
  if (cur < 0)
  begin
    for (int i = nocArbPkg::numPorts - 1; i >= 0; i--)
    begin
      if (reqMask[i])
        pick = i;                                // Last hit is the lowest index
    end
  end
  else if (reqMask[cur] && !upMask[cur])
    pick = cur;
  else
  begin
    for (int k = nocArbPkg::numPorts - 1; k >= 1; k--)
    begin
      p = (cur + k) % nocArbPkg::numPorts;
      if (reqMask[p])
        pick = p;                                // Nearest port after the holder wins
    end
  end
  return pick;
endfunction

function automatic logic [nocArbPkg::lengthWidth-1:0] nextCount(
  input logic [nocArbPkg::lengthWidth-1:0] cnt, input logic run);
  if (run)
    return cnt + 1'b1;
  return '0;
endfunction

function automatic nocArbPkg::arbStateT grantCode(input int idx);
  logic [nocArbPkg::stateWidth-1:0] bits;
  bits = 1;
  if (idx >= 0)
    bits = 2 << idx;
  return nocArbPkg::arbStateT'(bits);
endfunction

function automatic nocArbPkg::flitT expectedFlit(input int idx,
                                                 input nocArbPkg::flitT [nocArbPkg::numPorts-1:0] f);
  nocArbPkg::flitT e;
  e = '0;
  e.kind = nocArbPkg::flitNone;
  if (idx >= 0)
    e = f[idx];
  return e;
endfunction

`endif

/* tb/tbRouterOutputPort.sv */
`timescale 1ns/1ps
`default_nettype none

module tbRouterOutputPort;

  localparam int clkPeriod = 4;
  localparam int resetCycles = 16;
  localparam int numRows = 36;
  localparam int randomCycles = 400;
  localparam int watchdogNs = (resetCycles + numRows + randomCycles + 50) * clkPeriod;
  localparam logic [15:0] lfsrSeed = 16'd93;

  typedef struct packed
  {
    logic [nocArbPkg::numPorts-1:0]    reqMask;
    logic [nocArbPkg::numPorts-1:0]    hdrMask;
    logic [nocArbPkg::lengthWidth-1:0] len;
    nocArbPkg::arbStateT               expGrant;   // Grant after the edge that ends the row
  } rowT;

  logic                                          clk;
  logic                                          rst;
  logic [nocArbPkg::numPorts-1:0]                reqs;
  nocArbPkg::flitT [nocArbPkg::numPorts-1:0]     flits;
  nocArbPkg::arbStateT                           grant;
  nocArbPkg::flitT                               outFlit;
  logic                                          outValid;
  logic [nocArbPkg::portIdxWidth-1:0]            outPort;

  rowT rows [numRows];
  int modelGrant;
  logic [nocArbPkg::lengthWidth-1:0] modelLen [nocArbPkg::numPorts];
  logic [nocArbPkg::lengthWidth-1:0] modelCnt [nocArbPkg::numPorts];
  int cycleNum;
  logic [15:0] lfsrState;

  `include "arbModel.svh"

  routerOutputPort uut
  (
    .clk      (clk),
    .rst      (rst),
    .reqs     (reqs),
    .flits    (flits),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outPort  (outPort)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial
  begin
    #(watchdogNs);
    $display("Timeout: the run did not finish within %0d ns", watchdogNs);
    $display("SIMULATION FAILED");
    $fatal(1, "Watchdog expired");
  end

  task automatic reportError(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    $display("SIMULATION FAILED");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  function automatic logic [15:0] stepLfsr(input logic [15:0] s);
    if (s[0])
      return (s >> 1) ^ 16'hB400;
    return s >> 1;
  endfunction

  task automatic takeBit(output logic b);
    lfsrState = stepLfsr(lfsrState);
    b = lfsrState[0];
  endtask

  // Port order in the masks is {South, West, East, North, Local}
  task automatic loadTable();
    rows[0]  = {5'b00000, 5'b00000, 12'd0, nocArbPkg::stateIdle};
    rows[1]  = {5'b11110, 5'b00000, 12'd0, nocArbPkg::stateNorth};   // Idle picks lowest index
    rows[2]  = {5'b00000, 5'b00000, 12'd0, nocArbPkg::stateIdle};
    rows[3]  = {5'b11000, 5'b00000, 12'd0, nocArbPkg::stateWest};
    rows[4]  = {5'b00000, 5'b00000, 12'd0, nocArbPkg::stateIdle};
    rows[5]  = {5'b10000, 5'b00000, 12'd0, nocArbPkg::stateSouth};
    rows[6]  = {5'b00000, 5'b00000, 12'd0, nocArbPkg::stateIdle};
    rows[7]  = {5'b01000, 5'b01000, 12'd5, nocArbPkg::stateWest};    // West header, length 5
    rows[8]  = {5'b11100, 5'b00000, 12'd0, nocArbPkg::stateWest};
    rows[9]  = {5'b11100, 5'b00000, 12'd0, nocArbPkg::stateWest};
    rows[10] = {5'b11100, 5'b00000, 12'd0, nocArbPkg::stateWest};
    rows[11] = {5'b11100, 5'b00000, 12'd0, nocArbPkg::stateWest};
    rows[12] = {5'b11100, 5'b00000, 12'd0, nocArbPkg::stateWest};
    rows[13] = {5'b11100, 5'b00000, 12'd0, nocArbPkg::stateSouth};   // Cyclic order, not East
    rows[14] = {5'b11100, 5'b00000, 12'd0, nocArbPkg::stateEast};
    rows[15] = {5'b00000, 5'b00000, 12'd0, nocArbPkg::stateIdle};
    rows[16] = {5'b00001, 5'b00001, 12'd1, nocArbPkg::stateLocal};
    rows[17] = {5'b00011, 5'b00010, 12'd0, nocArbPkg::stateLocal};   // North latches 0 unowned
    rows[18] = {5'b00011, 5'b00000, 12'd0, nocArbPkg::stateNorth};
    rows[19] = {5'b00011, 5'b00000, 12'd0, nocArbPkg::stateLocal};
    rows[20] = {5'b00011, 5'b00000, 12'd0, nocArbPkg::stateLocal};
    rows[21] = {5'b00010, 5'b00000, 12'd0, nocArbPkg::stateNorth};   // Local drops as its hold ends
    rows[22] = {5'b00000, 5'b00000, 12'd0, nocArbPkg::stateIdle};
    rows[23] = {5'b01000, 5'b00000, 12'd0, nocArbPkg::stateWest};
    rows[24] = {5'b01000, 5'b00000, 12'd0, nocArbPkg::stateWest};
    rows[25] = {5'b00100, 5'b00100, 12'd3, nocArbPkg::stateEast};    // West drops mid hold
    rows[26] = {5'b00000, 5'b00000, 12'd0, nocArbPkg::stateIdle};    // East drops mid hold
    rows[27] = {5'b11111, 5'b11111, 12'd0, nocArbPkg::stateLocal};
    rows[28] = {5'b11111, 5'b00000, 12'd0, nocArbPkg::stateNorth};
    rows[29] = {5'b11111, 5'b00000, 12'd0, nocArbPkg::stateEast};
    rows[30] = {5'b11111, 5'b00000, 12'd0, nocArbPkg::stateWest};
    rows[31] = {5'b11111, 5'b00000, 12'd0, nocArbPkg::stateSouth};
    rows[32] = {5'b11111, 5'b00000, 12'd0, nocArbPkg::stateLocal};
    rows[33] = {5'b00001, 5'b00000, 12'd0, nocArbPkg::stateIdle};    // Lone expiring port waits
    rows[34] = {5'b00001, 5'b00000, 12'd0, nocArbPkg::stateLocal};
    rows[35] = {5'b00000, 5'b00000, 12'd0, nocArbPkg::stateIdle};
  endtask

  // Called 1 ns after a rising edge, returns 1 ns after the next one
  task automatic runCycle(input logic [nocArbPkg::numPorts-1:0] reqMask,
                          input logic [nocArbPkg::numPorts-1:0] hdrMask,
                          input logic [nocArbPkg::lengthWidth-1:0] len);
    nocArbPkg::flitT expFlit;
    logic expValid;
    logic [nocArbPkg::numPorts-1:0] upMask;
    logic run;
    int nextIdx;

    reqs = reqMask;
    for (int i = 0; i < nocArbPkg::numPorts; i++)
    begin
      if (hdrMask[i])
        flits[i].kind = nocArbPkg::flitHeader;
      else if (reqMask[i])
        flits[i].kind = nocArbPkg::flitBody;
      else
        flits[i].kind = nocArbPkg::flitNone;
      flits[i].length = len;
      flits[i].payload = 32'((cycleNum << 4) + i);
    end
    cycleNum++;

    #2;
    expFlit = expectedFlit(modelGrant, flits);
    expValid = 1'b0;
    if (modelGrant >= 0)
      expValid = reqMask[modelGrant];
    assert (outValid === expValid)
      else reportError($sformatf("outValid is %b, expected %b", outValid, expValid));
    assert (outFlit === expFlit)
      else reportError($sformatf("outFlit is %h, expected %h", outFlit, expFlit));
    if (modelGrant >= 0)
    begin
      assert (outPort === modelGrant[nocArbPkg::portIdxWidth-1:0])
        else reportError($sformatf("outPort is %0d, expected %0d", outPort, modelGrant));
    end

    for (int i = 0; i < nocArbPkg::numPorts; i++)
      upMask[i] = (modelCnt[i] == modelLen[i]);
    run = (modelGrant >= 0) && reqMask[modelGrant] && !upMask[modelGrant];
    nextIdx = predictGrant(modelGrant, reqMask, upMask);
    for (int i = 0; i < nocArbPkg::numPorts; i++)
    begin
      modelCnt[i] = nextCount(modelCnt[i], run && (i == modelGrant));
      if (hdrMask[i])
        modelLen[i] = len;                     // Headers load even on ports without the grant
    end
    modelGrant = nextIdx;

    @(posedge clk);
    #1;
    assert (grant === grantCode(modelGrant))
      else reportError($sformatf("grant is %b, model expects %b", grant, grantCode(modelGrant)));
  endtask

  initial
  begin
    logic [nocArbPkg::numPorts-1:0] rndReq;
    logic [nocArbPkg::numPorts-1:0] rndHdr;
    logic [2:0] rndLen;
    logic b;

    rst = 1'b1;
    reqs = '1;                                 // Every port requests across reset
    flits = '0;
    modelGrant = -1;
    for (int i = 0; i < nocArbPkg::numPorts; i++)
    begin
      modelLen[i] = '0;
      modelCnt[i] = '0;
    end
    cycleNum = 0;
    lfsrState = lfsrSeed;
    loadTable();

    repeat (resetCycles) @(posedge clk);
    #1;
    rst = 1'b0;
    #1;
    assert (grant === nocArbPkg::stateIdle)
      else reportError($sformatf("grant after reset is %b, expected idle", grant));
    assert (outValid === 1'b0)
      else reportError("outValid is high right after reset");
    @(posedge clk);
    #1;
    assert (grant === nocArbPkg::stateLocal)
      else reportError($sformatf("first grant is %b, expected Local", grant));
    modelGrant = 0;                            // Idle hands the output to Local first

    for (int r = 0; r < numRows; r++)
    begin
      runCycle(rows[r].reqMask, rows[r].hdrMask, rows[r].len);
      assert (grant === rows[r].expGrant)
        else reportError($sformatf("row %0d grant is %b, table expects %b",
                                   r, grant, rows[r].expGrant));
    end

    for (int n = 0; n < randomCycles; n++)
    begin
      for (int i = 0; i < nocArbPkg::numPorts; i++)
      begin
        takeBit(b);
        rndReq[i] = b;
      end
      for (int i = 0; i < nocArbPkg::numPorts; i++)
      begin
        takeBit(b);
        rndHdr[i] = b;
      end
      for (int i = 0; i < 3; i++)
      begin
        takeBit(b);
        rndLen[i] = b;
      end
      runCycle(rndReq, rndHdr, {{(nocArbPkg::lengthWidth-3){1'b0}}, rndLen});
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/flitSelector.sv */
`timescale 1ns/1ps
`default_nettype none

module flitSelector
(
  input  nocArbPkg::arbStateT                           grant,
  input  logic [nocArbPkg::numPorts-1:0]                reqs,
  input  nocArbPkg::flitT [nocArbPkg::numPorts-1:0]     flits,
  output nocArbPkg::flitT                               outFlit,
  output logic                                          outValid,
  output logic [nocArbPkg::portIdxWidth-1:0]            outPort
);

  logic [nocArbPkg::portIdxWidth-1:0] grantIdx;
  logic                               granted;

  assign grantIdx = nocArbPkg::stateToIndex(grant);
  assign granted = (grant != nocArbPkg::stateIdle);

  always_comb
  begin
    if (granted)
    begin
      outFlit = flits[grantIdx];
    end
    else
    begin
      outFlit = '0;
      outFlit.kind = nocArbPkg::flitNone;      // Empty slot while nobody owns the output
    end
  end

  // A granted port whose request already dropped sends nothing this cycle
  assign outValid = granted && reqs[grantIdx];
  assign outPort = grantIdx;

endmodule

`default_nettype wire

/* verilog/holdTimerBank.sv */
`timescale 1ns/1ps
`default_nettype none

module holdTimerBank
(
  input  logic                                          clk,
  input  logic                                          rst,
  input  nocArbPkg::flitT [nocArbPkg::numPorts-1:0]     flits,
  input  logic [nocArbPkg::numPorts-1:0]                runTimers,
  output logic [nocArbPkg::numPorts-1:0]                timesUp
);

  logic [nocArbPkg::lengthWidth-1:0] lengthRegs [nocArbPkg::numPorts];
  logic [nocArbPkg::lengthWidth-1:0] holdCounts [nocArbPkg::numPorts];

  for (genvar i = 0; i < nocArbPkg::numPorts; i++)
  begin : perPort

    always_ff @(posedge clk)
    begin
      if (rst)
      begin
        lengthRegs[i] <= '0;
        holdCounts[i] <= '0;
      end
      else
      begin
        // A header on the port reloads the length even while another port holds the output
        if (flits[i].kind == nocArbPkg::flitHeader)
          lengthRegs[i] <= flits[i].length;

        if (runTimers[i])
          holdCounts[i] <= holdCounts[i] + 1'b1;   // Counts only while the grant is held
        else
          holdCounts[i] <= '0;
      end
    end

    assign timesUp[i] = (holdCounts[i] == lengthRegs[i]);   // Hold ends in the cycle count hits L

  end

endmodule

`default_nettype wire

/* verilog/nocArbPkg.sv */
`default_nettype none

package nocArbPkg;

  localparam int numPorts = 5;       // Local, North, East, West, South
  localparam int portIdxWidth = 3;
  localparam int stateWidth = numPorts + 1;
  localparam int lengthWidth = 12;
  localparam int payloadWidth = 32;

  typedef enum logic [2:0]
  {
    flitNone   = 3'd0,
    flitHeader = 3'd1,
    flitBody   = 3'd2,
    flitTail   = 3'd3
  } flitKindT;

  typedef struct packed
  {
    flitKindT                  kind;
    logic [lengthWidth-1:0]    length;   // Only meaningful on a header flit
    logic [payloadWidth-1:0]   payload;
  } flitT;

  // One-hot grant state, bit 0 is idle and bit i+1 is port i
  typedef enum logic [stateWidth-1:0]
  {
    stateIdle  = 6'b000001,
    stateLocal = 6'b000010,
    stateNorth = 6'b000100,
    stateEast  = 6'b001000,
    stateWest  = 6'b010000,
    stateSouth = 6'b100000
  } arbStateT;

  function automatic logic [portIdxWidth-1:0] stateToIndex(input arbStateT state);
    logic [portIdxWidth-1:0] idx;
    idx = '0;                                  // Idle maps to 0 as well
    for (int i = 0; i < numPorts; i++)
    begin
      if (state[i + 1])
        idx = i[portIdxWidth-1:0];
    end
    return idx;
  endfunction

  function automatic arbStateT indexToState(input logic [portIdxWidth-1:0] idx);
    logic [stateWidth-1:0] bits;
    bits = '0;
    bits[idx + 1] = 1'b1;
    return arbStateT'(bits);
  endfunction

endpackage

`default_nettype wire

/* verilog/portArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module portArbiter
(
  input  logic                              clk,
  input  logic                              rst,
  input  logic [nocArbPkg::numPorts-1:0]    reqs,
  input  logic [nocArbPkg::numPorts-1:0]    timesUp,
  output nocArbPkg::arbStateT               grant,
  output logic [nocArbPkg::numPorts-1:0]    runTimers
);

  nocArbPkg::arbStateT nextGrant;

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= nocArbPkg::stateIdle;
    else
      grant <= nextGrant;
  end

  always_comb
  begin : nextGrantLogic
    logic [nocArbPkg::portIdxWidth-1:0] heldIdx;
    logic [nocArbPkg::portIdxWidth-1:0] pickIdx;
    int unsigned cand;
    logic found;

    heldIdx = nocArbPkg::stateToIndex(grant);
    pickIdx = '0;
    cand = 0;
    found = 1'b0;
    runTimers = '0;

    case (grant)
      nocArbPkg::stateIdle:
      begin
        // Fixed priority from idle, lowest index wins
        for (int i = 0; i < nocArbPkg::numPorts; i++)
        begin
          if (reqs[i] && !found)
          begin
            found = 1'b1;
            pickIdx = i[nocArbPkg::portIdxWidth-1:0];
          end
        end
      end

      nocArbPkg::stateLocal,
      nocArbPkg::stateNorth,
      nocArbPkg::stateEast,
      nocArbPkg::stateWest,
      nocArbPkg::stateSouth:
      begin
        if (reqs[heldIdx] && !timesUp[heldIdx])
        begin
          runTimers[heldIdx] = 1'b1;             // Hold cycle, keep the packet on the output
          found = 1'b1;
          pickIdx = heldIdx;
        end
        else
        begin
          // Rotate through the ports after the holder, never back to the holder itself
          for (int k = 1; k < nocArbPkg::numPorts; k++)
          begin
            cand = heldIdx + k;
            if (cand >= nocArbPkg::numPorts)
              cand = cand - nocArbPkg::numPorts;
            if (reqs[cand] && !found)
            begin
              found = 1'b1;
              pickIdx = cand[nocArbPkg::portIdxWidth-1:0];
            end
          end
        end
      end

      default:
      begin
        found = 1'b0;                            // Illegal encoding drops back to idle
      end
    endcase

    if (found)
      nextGrant = nocArbPkg::indexToState(pickIdx);
    else
      nextGrant = nocArbPkg::stateIdle;
  end

endmodule

`default_nettype wire

/* verilog/routerOutputPort.sv */
`timescale 1ns/1ps
`default_nettype none

module routerOutputPort
(
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic [nocArbPkg::numPorts-1:0]                reqs,
  input  nocArbPkg::flitT [nocArbPkg::numPorts-1:0]     flits,
  output nocArbPkg::arbStateT                           grant,
  output nocArbPkg::flitT                               outFlit,
  output logic                                          outValid,
  output logic [nocArbPkg::portIdxWidth-1:0]            outPort
);

  logic [nocArbPkg::numPorts-1:0] runTimers;
  logic [nocArbPkg::numPorts-1:0] timesUp;

  // Arbiter and timers run side by side and trade run and time-up levels
  portArbiter arbiter
  (
    .clk       (clk),
    .rst       (rst),
    .reqs      (reqs),
    .timesUp   (timesUp),
    .grant     (grant),
    .runTimers (runTimers)
  );

  holdTimerBank timers
  (
    .clk       (clk),
    .rst       (rst),
    .flits     (flits),
    .runTimers (runTimers),
    .timesUp   (timesUp)
  );

  flitSelector selector
  (
    .grant     (grant),
    .reqs      (reqs),
    .flits     (flits),
    .outFlit   (outFlit),
    .outValid  (outValid),
    .outPort   (outPort)
  );

endmodule

`default_nettype wire
